//--- filelist.f
hw/uart_cmd_pkg.sv
hw/uart_tx_frame.sv
hw/uart_rx_frame.sv
hw/uart_cmd_seq.sv
hw/uart_cmd_top.sv
sim/uart_cmd_chk.sv
sim/uart_cmd_tb.sv

//--- hw/uart_cmd_pkg.sv
package uart_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // frame timing
  ////////////////////////////////////////////////////////////

  // clock cycles per bit and the receiver mid-bit offset.
  localparam int BIT_CYCLES      = 435;
  localparam int HALF_BIT_CYCLES = 217;

  // start, eight data, parity, stop.
  localparam int FRAME_BITS = 11;

  // idle bit times between address and data frame of a write.
  localparam int GAP_BITS = 16;

  // bit times a read waits for the response start bit.
  localparam int RESP_TIMEOUT_BITS = 64;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [7:0]  uart_byte_t;
  typedef logic [15:0] cmd_word_t;
  typedef logic [6:0]  reg_addr_t;
  typedef logic [8:0]  baud_cnt_t;
  typedef logic [3:0]  bit_idx_t;
  typedef logic [6:0]  wait_cnt_t;

  // valid marks one received frame for a single cycle.
  typedef struct packed {
    logic       valid;
    uart_byte_t data;
    logic       parity_err;
    logic       frame_err;
  } rx_result_t;

endpackage

//--- hw/uart_cmd_seq.sv
`timescale 1ns/1ps

module uart_cmd_seq
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_t  cmd_in,
  input  logic       cmd_vld,
  input  logic       tx_done,
  input  rx_result_t rx_res,
  output logic       cmd_rdy,
  output logic       tx_start,
  output uart_byte_t tx_byte,
  output logic       read_rdy,
  output uart_byte_t read_data,
  output logic       read_err
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_ADDR,
    ST_GAP,
    ST_SEND_DATA,
    ST_WAIT_RESP,
    ST_FINISH
  } seq_state_t;

  seq_state_t state;
  cmd_word_t  cmd_q;
  reg_addr_t  addr;
  baud_cnt_t  baud_cnt;
  wait_cnt_t  wait_cnt;
  wait_cnt_t  wait_last;
  logic       wait_end;
  logic       accept;
  logic       resp_err;

  assign accept  = cmd_vld && cmd_rdy;
  assign addr    = cmd_q[14:8];
  assign tx_byte = (state == ST_SEND_DATA) ? cmd_q[7:0] : {cmd_q[15], addr};

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  ////////////////////////////////////////////////////////////
  // gap and timeout timer
  ////////////////////////////////////////////////////////////

  assign wait_last = (state == ST_GAP) ? wait_cnt_t'(GAP_BITS - 1)
                                       : wait_cnt_t'(RESP_TIMEOUT_BITS - 1);
  assign wait_end  = (baud_cnt == baud_cnt_t'(BIT_CYCLES - 1)) && (wait_cnt == wait_last);

  // starts at one to absorb the cycle of the tx_start strobe.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      baud_cnt <= baud_cnt_t'(1);
      wait_cnt <= '0;
    end
    else if (state == ST_GAP || state == ST_WAIT_RESP)
    begin
      if (baud_cnt == baud_cnt_t'(BIT_CYCLES - 1))
      begin
        baud_cnt <= '0;
        wait_cnt <= wait_cnt + 1'b1;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
    else
    begin
      baud_cnt <= baud_cnt_t'(1);
      wait_cnt <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // command FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
      read_err  <= 1'b0;
      read_data <= '0;
      resp_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            state    <= ST_SEND_ADDR;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
          end
        end
        ST_SEND_ADDR:
        begin
          if (tx_done)
            state <= cmd_q[15] ? ST_GAP : ST_WAIT_RESP;
        end
        ST_GAP:
        begin
          if (wait_end)
          begin
            state    <= ST_SEND_DATA;
            tx_start <= 1'b1;
          end
        end
        ST_SEND_DATA:
        begin
          if (tx_done)
          begin
            state   <= ST_IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        ST_WAIT_RESP:
        begin
          // a frame in the last timeout cycle still counts.
          if (rx_res.valid)
          begin
            state     <= ST_FINISH;
            read_data <= rx_res.data;
            resp_err  <= rx_res.parity_err | rx_res.frame_err;
          end
          else if (wait_end)
          begin
            state     <= ST_FINISH;
            read_data <= '0;
            resp_err  <= 1'b1;
          end
        end
        ST_FINISH:
        begin
          state    <= ST_IDLE;
          cmd_rdy  <= 1'b1;
          read_rdy <= 1'b1;
          read_err <= resp_err;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- hw/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_t  cmd_in,
  input  logic       cmd_vld,
  input  logic       rx,
  output logic       tx,
  output logic       cmd_rdy,
  output logic       read_rdy,
  output uart_byte_t read_data,
  output logic       read_err
);

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_done;
  rx_result_t rx_res;

  uart_cmd_seq i_uart_cmd_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .tx_done   (tx_done),
    .rx_res    (rx_res),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // the receiver listens all the time; the sequencer picks what it needs.
  uart_rx_frame i_uart_rx_frame (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_res (rx_res)
  );

endmodule

//--- hw/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output rx_result_t rx_res
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_t;

  rx_state_t  state;
  logic       rx_s1;
  logic       rx_s2;
  logic       rx_d;
  logic       fall;
  logic       sample;
  baud_cnt_t  baud_cnt;
  bit_idx_t   bit_idx;
  uart_byte_t data_q;
  logic       par_q;

  ////////////////////////////////////////////////////////////
  // synchronizer and edge detect
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  assign fall = rx_d & ~rx_s2;

  // half a bit into the start bit, then one full bit per sample.
  assign sample = (state == ST_START) ? (baud_cnt == baud_cnt_t'(HALF_BIT_CYCLES - 1))
                                      : (baud_cnt == baud_cnt_t'(BIT_CYCLES - 1));

  ////////////////////////////////////////////////////////////
  // deserializer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      baud_cnt <= (state == ST_IDLE || sample) ? '0 : baud_cnt + 1'b1;
      case (state)
        ST_IDLE:
        begin
          if (fall)
            state <= ST_START;
        end
        ST_START:
        begin
          // a start bit that is high again was a glitch.
          if (sample)
          begin
            state   <= rx_s2 ? ST_IDLE : ST_DATA;
            bit_idx <= '0;
          end
        end
        ST_DATA:
        begin
          if (sample)
          begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd7)
              state <= ST_PARITY;
          end
        end
        ST_PARITY:
        begin
          if (sample)
            state <= ST_STOP;
        end
        ST_STOP:
        begin
          if (sample)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_DATA && sample)
      data_q <= {rx_s2, data_q[7:1]};
    if (state == ST_PARITY && sample)
      par_q <= rx_s2;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rx_res <= '0;
    else
    begin
      rx_res.valid <= 1'b0;
      if (state == ST_STOP && sample)
      begin
        rx_res.valid      <= 1'b1;
        rx_res.data       <= data_q;
        rx_res.parity_err <= (par_q != ~^data_q);
        rx_res.frame_err  <= ~rx_s2;
      end
    end
  end

endmodule

//--- hw/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  uart_byte_t tx_byte,
  output logic       tx,
  output logic       tx_done
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } tx_state_t;

  // frame position of data bit 7.
  localparam bit_idx_t LAST_DATA_IDX = 4'd8;

  tx_state_t  state;
  baud_cnt_t  baud_cnt;
  bit_idx_t   bit_idx;
  uart_byte_t byte_q;
  logic       baud_end;

  assign baud_end = (baud_cnt == baud_cnt_t'(BIT_CYCLES - 1));
  assign tx_done  = (state == ST_STOP) && baud_end;

  always_ff @(posedge clk)
  begin
    if (tx_start && state == ST_IDLE)
      byte_q <= tx_byte;
  end

  // tx is registered so the line never glitches between bits.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      if (state != ST_IDLE)
        baud_cnt <= baud_end ? '0 : baud_cnt + 1'b1;
      if (state != ST_IDLE && baud_end)
        bit_idx <= bit_idx + 1'b1;

      case (state)
        ST_IDLE:
        begin
          if (tx_start)
          begin
            state   <= ST_START;
            bit_idx <= '0;
            tx      <= 1'b0;
          end
        end
        ST_START, ST_DATA:
        begin
          if (baud_end)
          begin
            if (bit_idx == LAST_DATA_IDX)
            begin
              state <= ST_PARITY;
              tx    <= ~^byte_q;
            end
            else
            begin
              state <= ST_DATA;
              tx    <= byte_q[bit_idx[2:0]];
            end
          end
        end
        ST_PARITY:
        begin
          if (baud_end)
          begin
            state <= ST_STOP;
            tx    <= 1'b1;
          end
        end
        ST_STOP:
        begin
          if (baud_end)
            state <= ST_IDLE;
        end
        default:
        begin
          state <= ST_IDLE;
          tx    <= 1'b1;
        end
      endcase
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module uart_cmd_tb -f filelist.f -o uart_cmd_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/uart_cmd_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- sim/uart_cmd_chk.sv
`timescale 1ns/1ps

module uart_cmd_chk (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy,
  input logic read_err
);

  int fail_count = 0;

  // the line rests high whenever a command can be taken.
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else
    begin
      $error("tx is low while cmd_rdy is high");
      fail_count = fail_count + 1;
    end

  a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else
    begin
      $error("read_rdy stayed high for more than one cycle");
      fail_count = fail_count + 1;
    end

  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
                             cmd_vld && cmd_rdy |=> !cmd_rdy)
    else
    begin
      $error("cmd_rdy still high after a command was accepted");
      fail_count = fail_count + 1;
    end

  a_err_with_rdy: assert property (@(posedge clk) disable iff (!rst_n) read_err |-> read_rdy)
    else
    begin
      $error("read_err is high without read_rdy");
      fail_count = fail_count + 1;
    end

endmodule

bind uart_cmd_top uart_cmd_chk i_uart_cmd_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy),
  .read_err (read_err)
);

//--- sim/uart_cmd_tb.sv
`timescale 1ns/1ps

module uart_cmd_tb
  import uart_cmd_pkg::*;
;

  localparam int CLK_PERIOD = 40;

  // response modes of the line model on rx.
  localparam int MODE_GOOD       = 0;
  localparam int MODE_BAD_PARITY = 1;
  localparam int MODE_LOW_STOP   = 2;
  localparam int MODE_SILENT     = 3;

  // three writes, one idle watch, four reads at their worst case.
  localparam int TEST_BITS   = 3 * (2 * FRAME_BITS + GAP_BITS) + 2 * FRAME_BITS
                               + 4 * (FRAME_BITS + 1 + RESP_TIMEOUT_BITS + 2);
  localparam int WATCHDOG_NS = (TEST_BITS * BIT_CYCLES * CLK_PERIOD / 10) * 12
                               + 32 * CLK_PERIOD;
  localparam int MIN_WRITE_NS = (FRAME_BITS + GAP_BITS) * BIT_CYCLES * CLK_PERIOD;

  logic       clk = 1'b0;
  logic       rst_n;
  cmd_word_t  cmd_in;
  logic       cmd_vld;
  logic       rx;
  logic       tx;
  logic       cmd_rdy;
  logic       read_rdy;
  uart_byte_t read_data;
  logic       read_err;

  integer seed = 17016;
  int     value_errs = 0;
  int     proto_errs = 0;

  uart_cmd_top i_uart_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // compare and report
  ////////////////////////////////////////////////////////////

  // parity bit that makes the count of ones in the frame odd.
  function automatic logic odd_parity(input uart_byte_t b);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i = i + 1)
      ones = ones + b[i];
    return (ones % 2) == 0;
  endfunction

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (act !== exp)
    begin
      $display("Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
      value_errs = value_errs + 1;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Error %s: expected %0b, actual %0b", name, exp, act);
      value_errs = value_errs + 1;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    proto_errs = proto_errs + 1;
  endtask

  ////////////////////////////////////////////////////////////
  // line models
  ////////////////////////////////////////////////////////////

  // waits for a start bit on tx and samples every bit at mid-bit.
  task automatic recv_frame(input int limit, output logic ok, output uart_byte_t data,
                            output logic par, output logic stop, output int t_start);
    int waited;
    int i;
    waited  = 0;
    ok      = 1'b0;
    data    = '0;
    par     = 1'b0;
    stop    = 1'b0;
    t_start = 0;
    @(negedge clk);
    while (tx !== 1'b0 && waited < limit)
    begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (tx === 1'b0)
    begin
      ok      = 1'b1;
      t_start = int'($time);
      repeat (HALF_BIT_CYCLES) @(negedge clk);
      for (i = 0; i < 8; i = i + 1)
      begin
        repeat (BIT_CYCLES) @(negedge clk);
        data = {tx, data[7:1]};
      end
      repeat (BIT_CYCLES) @(negedge clk);
      par = tx;
      repeat (BIT_CYCLES) @(negedge clk);
      stop = tx;
    end
  endtask

  task automatic drive_frame(input uart_byte_t data, input logic bad_par, input logic low_stop);
    logic [10:0] bits;
    int          i;
    bits = {~low_stop, odd_parity(data) ^ bad_par, data, 1'b0};
    @(posedge clk);
    for (i = 0; i < FRAME_BITS; i = i + 1)
    begin
      rx   <= bits[0];
      bits = bits >> 1;
      repeat (BIT_CYCLES) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  task automatic wait_read(input int limit, output logic seen, output uart_byte_t data,
                           output logic err, output logic rdy, output int cycles);
    cycles = 0;
    seen   = 1'b0;
    data   = '0;
    err    = 1'b0;
    rdy    = 1'b0;
    @(negedge clk);
    while (read_rdy !== 1'b1 && cycles < limit)
    begin
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (read_rdy === 1'b1)
    begin
      seen = 1'b1;
      data = read_data;
      err  = read_err;
      rdy  = cmd_rdy;
    end
  endtask

  task automatic wait_cmd_rdy(input string name, input int limit);
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1 && waited < limit)
    begin
      @(negedge clk);
      waited = waited + 1;
    end
    if (cmd_rdy !== 1'b1)
      report_failure({name, ": cmd_rdy did not return high"});
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  // with busy set, cmd_vld stays high one more cycle with another word.
  task automatic send_cmd(input cmd_word_t cmd, input logic busy, input cmd_word_t busy_cmd);
    @(negedge clk);
    if (cmd_rdy !== 1'b1)
      report_failure("cmd_rdy was low when a command was due");
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    if (busy)
    begin
      cmd_in <= busy_cmd;
      @(posedge clk);
    end
    cmd_vld <= 1'b0;
  endtask

  task automatic check_frame(input string name, input logic ok, input uart_byte_t exp,
                             input uart_byte_t b, input logic par, input logic stop);
    if (!ok)
      report_failure({name, ": no frame appeared on tx"});
    else
    begin
      check_byte(name, exp, b);
      check_bit({name, " parity"}, odd_parity(b), par);
      check_bit({name, " stop"}, 1'b1, stop);
    end
  endtask

  task automatic check_reset();
    repeat (8) @(negedge clk);
    check_bit("reset tx", 1'b1, tx);
    check_bit("reset cmd_rdy", 1'b1, cmd_rdy);
    check_bit("reset read_rdy", 1'b0, read_rdy);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(negedge clk);
    check_bit("after reset tx", 1'b1, tx);
    check_bit("after reset cmd_rdy", 1'b1, cmd_rdy);
    check_bit("after reset read_rdy", 1'b0, read_rdy);
    check_bit("after reset read_err", 1'b0, read_err);
    check_byte("after reset read_data", 8'h00, read_data);
  endtask

  task automatic run_write(input string name, input logic busy);
    cmd_word_t  cmd;
    cmd_word_t  other;
    logic       ok;
    uart_byte_t b;
    logic       par;
    logic       stop;
    int         t_addr;
    int         t_data;
    cmd     = cmd_word_t'($random(seed));
    cmd[15] = 1'b1;
    other   = cmd_word_t'($random(seed));
    send_cmd(cmd, busy, other);
    recv_frame(8, ok, b, par, stop, t_addr);
    check_frame({name, " addr"}, ok, {1'b1, cmd[14:8]}, b, par, stop);
    recv_frame((GAP_BITS + 2) * BIT_CYCLES, ok, b, par, stop, t_data);
    check_frame({name, " data"}, ok, cmd[7:0], b, par, stop);
    if (ok && (t_data - t_addr) < MIN_WRITE_NS)
      report_failure({name, ": gap between the frames is too short"});
    wait_cmd_rdy(name, BIT_CYCLES);
  endtask

  task automatic run_read(input string name, input int mode);
    cmd_word_t  cmd;
    uart_byte_t resp;
    logic       ok;
    uart_byte_t b;
    logic       par;
    logic       stop;
    int         t_addr;
    logic       seen;
    uart_byte_t data;
    logic       err;
    logic       rdy;
    int         cycles;
    cmd     = cmd_word_t'($random(seed));
    cmd[15] = 1'b0;
    resp    = uart_byte_t'($random(seed));
    send_cmd(cmd, 1'b0, '0);
    recv_frame(8, ok, b, par, stop, t_addr);
    check_frame({name, " addr"}, ok, {1'b0, cmd[14:8]}, b, par, stop);
    if (mode == MODE_SILENT)
      wait_read((RESP_TIMEOUT_BITS + 2) * BIT_CYCLES, seen, data, err, rdy, cycles);
    else
    begin
      repeat (BIT_CYCLES) @(posedge clk);
      fork
        drive_frame(resp, mode == MODE_BAD_PARITY, mode == MODE_LOW_STOP);
        wait_read((FRAME_BITS + 2) * BIT_CYCLES, seen, data, err, rdy, cycles);
      join
    end
    if (!seen)
      report_failure({name, ": read_rdy never pulsed"});
    else
    begin
      check_bit({name, " read_err"}, mode != MODE_GOOD, err);
      check_bit({name, " cmd_rdy"}, 1'b1, rdy);
      if (mode == MODE_GOOD)
        check_byte({name, " read_data"}, resp, data);
      if (mode == MODE_SILENT)
        check_byte({name, " read_data"}, 8'h00, data);
      if (mode == MODE_SILENT && cycles < RESP_TIMEOUT_BITS * BIT_CYCLES)
        report_failure({name, ": the read gave up before the timeout"});
    end
  endtask

  task automatic run_busy();
    logic       ok;
    uart_byte_t b;
    logic       par;
    logic       stop;
    int         t_extra;
    run_write("busy write", 1'b1);
    recv_frame(2 * FRAME_BITS * BIT_CYCLES, ok, b, par, stop, t_extra);
    if (ok)
      report_failure("busy: the ignored command still produced a frame");
    run_write("write after busy", 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    check_reset();
    run_write("write", 1'b0);
    run_read("read", MODE_GOOD);
    run_read("read bad parity", MODE_BAD_PARITY);
    run_read("read low stop", MODE_LOW_STOP);
    run_read("read timeout", MODE_SILENT);
    run_busy();
    repeat (4) @(posedge clk);
    $display("value errors: %0d, protocol errors: %0d, assertion failures: %0d",
             value_errs, proto_errs, i_uart_cmd_top.i_uart_cmd_chk.fail_count);
    if (value_errs == 0 && proto_errs == 0 && i_uart_cmd_top.i_uart_cmd_chk.fail_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
